//--- design/fml_ram.sv
// ============================================================
// Block-RAM FML target. Acks ack_latency cycles after the
// strobe rises, ack_latency >= 1. Each request moves eight
// beats from the addressed word, wrapping within the line.
// The master must not strobe again until the burst is over.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module fml_ram
	import fmlbrg_pkg::*;
#(
	parameter int fml_depth = 13,
	parameter int ack_latency = 3
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst,

	input  wire [fml_depth-1:0] fml_adr_i,
	input  wire                 fml_stb_i,
	input  wire                 fml_we_i,
	input  wire [15:0]          fml_di_i,
	output logic                fml_ack_o,
	output logic [15:0]         fml_do_o
);

	localparam int LW = fml_depth - OFFSET_BITS - 1;

	logic [15:0] mem [0:(1<<(fml_depth-1))-1];

	logic [15:0] lat_cnt;
	logic active;
	logic we_r;
	logic [OFFSET_BITS-1:0] beat;
	logic [OFFSET_BITS-1:0] left;
	logic [LW-1:0] line_r;

	wire [LW-1:0] line = fml_adr_i[fml_depth-1:OFFSET_BITS+1];
	wire [OFFSET_BITS-1:0] start = fml_adr_i[OFFSET_BITS:1];
	wire launch = fml_stb_i && !active && (lat_cnt == 16'(ack_latency - 1));

	// the whole memory starts as zero.
	initial begin
		for (int i = 0; i < (1 << (fml_depth - 1)); i++) begin
			mem[i] = '0;
		end
	end

	// control: latency count, then eight active beats, the first one acked.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			lat_cnt <= '0;
			active <= 1'b0;
			fml_ack_o <= 1'b0;
			left <= '0;
		end else begin
			fml_ack_o <= launch;
			if (launch) begin
				lat_cnt <= '0;
				active <= 1'b1;
				left <= OFFSET_BITS'(LINE_WORDS - 1);
			end else if (active) begin
				if (left == '0) begin
					active <= 1'b0;
				end else begin
					left <= left - 1'b1;
				end
			end else if (fml_stb_i) begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	// datapath: beat 0 is read ahead so it is on the bus with the ack.
	// The burst direction is taken at launch, since fml_we_i is only held until the ack.
	always_ff @(posedge sys_clk) begin
		if (launch) begin
			line_r <= line;
			beat <= start;
			we_r <= fml_we_i;
			fml_do_o <= mem[{line, start}];
		end else if (active) begin
			if (we_r) begin
				mem[{line_r, beat}] <= fml_di_i;
			end
			beat <= beat + 1'b1;
			fml_do_o <= mem[{line_r, beat + 1'b1}];
		end
	end

	// no new request may start while a burst is still moving.
	a_no_stb_in_burst: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(active && !fml_ack_o) |-> !fml_stb_i);

endmodule : fml_ram

`default_nettype wire

//--- design/fmlbrg.sv
// ============================================================
// Direct-mapped write-back cache from 16-bit Wishbone to FML.
// Needs cache_depth >= 5 and fml_depth > cache_depth. Only
// one line operation runs at a time. Bursts are incrementing
// only, and a burst that leaves a line restarts its tag check.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module fmlbrg
	import fmlbrg_pkg::*;
#(
	parameter int fml_depth = 13,
	parameter int cache_depth = 9
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst,

	input  wire [fml_depth-1:1] wb_adr_i,
	input  wire [15:0]          wb_dat_i,
	input  wire [1:0]           wb_sel_i,
	input  wire [2:0]           wb_cti_i,
	input  wire                 wb_cyc_i,
	input  wire                 wb_stb_i,
	input  wire                 wb_we_i,
	input  wire                 wb_tga_i,
	output logic [15:0]         wb_dat_o,
	output logic                wb_ack_o,

	output logic [fml_depth-1:0] fml_adr_o,
	output logic                 fml_stb_o,
	output logic                 fml_we_o,
	output logic [15:0]          fml_do_o,
	input  wire                  fml_ack_i,
	input  wire  [15:0]          fml_di_i,

	input  wire                 dcb_stb_i,
	input  wire [fml_depth-1:1] dcb_adr_i,
	output logic [15:0]         dcb_dat_o,
	output logic                dcb_hit_o
);

	// address split: | tag | index | offset | byte |.
	localparam int IW = cache_depth - OFFSET_BITS - 1;
	localparam int TW = fml_depth - cache_depth;
	localparam logic [OFFSET_BITS-1:0] LAST_WORD = '1;

	typedef enum logic [3:0] {
		IDLE, TEST_HIT, WB_BURST, EVICT, EVICT_STREAM, REFILL, REFILL_WAIT,
		REFILL_STB, REFILL_ACK, REFILL_STREAM, TEST_INVALIDATE, INVALIDATE
	} state_t;

	localparam logic [1:0] BC_KEEP = 2'd0;
	localparam logic [1:0] BC_LOAD = 2'd1;
	localparam logic [1:0] BC_INC = 2'd2;

	wire [OFFSET_BITS-1:0] offset = wb_adr_i[OFFSET_BITS:1];
	wire [IW-1:0] index = wb_adr_i[cache_depth-1:OFFSET_BITS+1];
	wire [TW-1:0] tag = wb_adr_i[fml_depth-1:cache_depth];

	wire [OFFSET_BITS-1:0] dcb_offset = dcb_adr_i[OFFSET_BITS:1];
	wire [IW-1:0] dcb_index = dcb_adr_i[cache_depth-1:OFFSET_BITS+1];
	wire [TW-1:0] dcb_tag = dcb_adr_i[fml_depth-1:cache_depth];

	state_t state, next_state;
	logic [1:0] bc_sel;
	logic [OFFSET_BITS-1:0] bcounter, bcounter_next;
	logic index_load;
	logic [IW-1:0] index_r;
	logic [TW-1:0] tag_r;
	logic [OFFSET_BITS-1:0] offset_r;
	logic [IW-1:0] line_index;

	logic tagmem_we;
	logic di_valid, di_dirty;
	logic [TW+1:0] tagmem_di, tagmem_do, tagmem_do2;
	logic do_valid, do_dirty, do2_valid;
	logic [TW-1:0] do_tag, do2_tag;
	logic cache_hit;

	logic datamem_we_wb, datamem_we_fml;
	logic [1:0] datamem_we;
	logic [15:0] datamem_di, datamem_do, datamem_do2;
	logic [cache_depth-2:0] datamem_a, datamem_a2;
	logic [OFFSET_BITS-1:0] beat_off;

	logic refilling, dcb_can_hit;
	logic [TW-1:0] dcb_tag_r;

	// the request registers follow the bus until the line is committed to a refill.
	always_ff @(posedge sys_clk) begin
		if (index_load) begin
			index_r <= index;
			tag_r <= tag;
			offset_r <= offset;
		end
	end

	assign line_index = index_load ? index : index_r;

	// entries are {valid, dirty, tag}.
	assign tagmem_di = {di_valid, di_dirty, tag_r};
	assign do_valid = tagmem_do[TW+1];
	assign do_dirty = tagmem_do[TW];
	assign do_tag = tagmem_do[TW-1:0];
	assign do2_valid = tagmem_do2[TW+1];
	assign do2_tag = tagmem_do2[TW-1:0];
	assign cache_hit = do_valid & (do_tag == tag_r);

	fmlbrg_tagmem #(
		.depth(IW),
		.width(TW + 2)
	) tagmem_inst (
		.sys_clk(sys_clk),
		.a_i(line_index),
		.we_i(tagmem_we),
		.di_i(tagmem_di),
		.do_o(tagmem_do),
		.a2_i(dcb_index),
		.do2_o(tagmem_do2)
	);

	// the burst counter selects the word inside the current line.
	always_comb begin
		case (bc_sel)
			BC_LOAD: bcounter_next = offset;
			BC_INC: bcounter_next = bcounter + 1'b1;
			default: bcounter_next = bcounter;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bcounter <= '0;
		end else begin
			bcounter <= bcounter_next;
		end
	end

	// Wishbone data wins on its own lanes when both sources write.
	assign datamem_we = datamem_we_fml ? 2'b11 : (datamem_we_wb ? wb_sel_i : 2'b00);
	assign datamem_di[7:0] = (datamem_we_wb & wb_sel_i[0]) ? wb_dat_i[7:0] : fml_di_i[7:0];
	assign datamem_di[15:8] = (datamem_we_wb & wb_sel_i[1]) ? wb_dat_i[15:8] : fml_di_i[15:8];
	assign datamem_a = {line_index, bcounter_next};
	assign datamem_a2 = {dcb_index, dcb_offset};

	fmlbrg_datamem #(
		.depth(cache_depth - 1)
	) datamem_inst (
		.sys_clk(sys_clk),
		.a_i(datamem_a),
		.we_i(datamem_we),
		.di_i(datamem_di),
		.do_o(datamem_do),
		.a2_i(datamem_a2),
		.do2_o(datamem_do2)
	);

	assign wb_dat_o = datamem_do;
	assign fml_do_o = datamem_do;
	assign dcb_dat_o = datamem_do2;

	// eviction goes to the stored tag, refill to the requested one.
	// Both bursts start at the critical word.
	always_ff @(posedge sys_clk) begin
		if (state == TEST_HIT || state == TEST_INVALIDATE) begin
			fml_adr_o <= {do_tag, index_r, offset_r, 1'b0};
		end else if (state == REFILL) begin
			fml_adr_o <= {tag_r, index_r, offset_r, 1'b0};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// word offset of the beat being acked in a hit burst.
	// A read has already moved the counter to it, a write moves it now.
	assign beat_off = wb_we_i ? bcounter + 1'b1 : bcounter;

	always_comb begin
		next_state = state;
		bc_sel = BC_KEEP;
		index_load = 1'b1;
		tagmem_we = 1'b0;
		di_valid = 1'b0;
		di_dirty = 1'b0;
		datamem_we_wb = 1'b0;
		datamem_we_fml = 1'b0;
		wb_ack_o = 1'b0;
		fml_stb_o = 1'b0;
		fml_we_o = 1'b0;
		case (state)
			IDLE: begin
				bc_sel = BC_LOAD;
				if (wb_cyc_i & wb_stb_i) begin
					next_state = wb_tga_i ? TEST_INVALIDATE : TEST_HIT;
				end
			end
			TEST_HIT: begin
				if (cache_hit) begin
					wb_ack_o = 1'b1;
					if (wb_we_i) begin
						di_valid = 1'b1;
						di_dirty = 1'b1;
						tagmem_we = 1'b1;
						datamem_we_wb = 1'b1;
					end else begin
						// a read fetches the next word ahead of its ack.
						bc_sel = BC_INC;
					end
					if (wb_cti_i == CTI_INC_BURST && offset_r != LAST_WORD) begin
						next_state = WB_BURST;
					end else begin
						next_state = IDLE;
					end
				end else begin
					next_state = do_dirty ? EVICT : REFILL;
				end
			end
			WB_BURST: begin
				if (!wb_cyc_i) begin
					next_state = IDLE;
				end else if (wb_stb_i) begin
					wb_ack_o = 1'b1;
					bc_sel = BC_INC;
					datamem_we_wb = wb_we_i;
					if (wb_cti_i != CTI_INC_BURST || beat_off == LAST_WORD) begin
						next_state = IDLE;
					end
				end
			end
			EVICT: begin
				fml_stb_o = 1'b1;
				fml_we_o = 1'b1;
				if (fml_ack_i) begin
					bc_sel = BC_INC;
					next_state = EVICT_STREAM;
				end
			end
			EVICT_STREAM: begin
				// the counter wraps back to the critical word on the last beat.
				bc_sel = BC_INC;
				if (bcounter_next == offset_r) begin
					next_state = wb_tga_i ? INVALIDATE : REFILL;
				end
			end
			REFILL: begin
				di_valid = 1'b1;
				di_dirty = wb_we_i;
				// a DCB probe of this index still sees the old entry.
				if (!(dcb_stb_i && dcb_index == line_index)) begin
					tagmem_we = 1'b1;
					next_state = REFILL_WAIT;
				end
			end
			REFILL_WAIT: begin
				next_state = REFILL_STB;
			end
			REFILL_STB: begin
				bc_sel = BC_LOAD;
				fml_stb_o = 1'b1;
				datamem_we_fml = 1'b1;
				datamem_we_wb = wb_we_i;
				if (fml_ack_i) begin
					next_state = REFILL_ACK;
				end
			end
			REFILL_ACK: begin
				// the critical word was written last cycle and reads back now.
				wb_ack_o = 1'b1;
				index_load = 1'b0;
				datamem_we_fml = 1'b1;
				bc_sel = BC_INC;
				next_state = REFILL_STREAM;
			end
			REFILL_STREAM: begin
				index_load = 1'b0;
				datamem_we_fml = 1'b1;
				bc_sel = BC_INC;
				if (bcounter_next + 1'b1 == offset_r) begin
					next_state = IDLE;
				end
			end
			TEST_INVALIDATE: begin
				next_state = do_dirty ? EVICT : INVALIDATE;
			end
			INVALIDATE: begin
				tagmem_we = 1'b1;
				wb_ack_o = 1'b1;
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// no DCB hit on the index whose line is being refilled.
	assign refilling = (state == REFILL_WAIT) || (state == REFILL_STB) ||
		(state == REFILL_ACK) || (state == REFILL_STREAM);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dcb_can_hit <= 1'b0;
		end else begin
			// port two misses a same-cycle write, so such a probe never hits.
			dcb_can_hit <= dcb_stb_i &&
				!(refilling && dcb_index == line_index) &&
				!((|datamem_we) && datamem_a == datamem_a2);
		end
	end

	always_ff @(posedge sys_clk) begin
		dcb_tag_r <= dcb_tag;
	end

	assign dcb_hit_o = dcb_can_hit & do2_valid & (do2_tag == dcb_tag_r);

	// an ack always answers a live request.
	a_ack_needs_req: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i));

	// the FML request, its address and its direction are held until the target takes it.
	a_fml_stb_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(fml_stb_o && !fml_ack_i) |=>
		(fml_stb_o && $stable(fml_adr_o) && $stable(fml_we_o)));

	// in a hit burst the counter steps with the master's word address.
	a_burst_step: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(state == WB_BURST && wb_ack_o) |-> (beat_off == offset));

endmodule : fmlbrg

`default_nettype wire

//--- design/fmlbrg_datamem.sv
// ============================================================
// Line data RAM, 16-bit words with byte-lane write enables.
// Port one is write-first, so a word written in a cycle is
// read back in the next. Port two reads the stored value.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module fmlbrg_datamem
	import fmlbrg_pkg::*;
#(
	parameter int depth = 8
) (
	input  wire             sys_clk,

	input  wire [depth-1:0] a_i,
	input  wire [1:0]       we_i,
	input  wire [15:0]      di_i,
	output logic [15:0]     do_o,

	input  wire [depth-1:0] a2_i,
	output logic [15:0]     do2_o
);

	// one array per byte lane keeps the lane enables simple.
	logic [7:0] lane0 [0:(1<<depth)-1];
	logic [7:0] lane1 [0:(1<<depth)-1];

	// the low lane.
	always_ff @(posedge sys_clk) begin
		if (we_i[0]) begin
			lane0[a_i] <= di_i[7:0];
			do_o[7:0] <= di_i[7:0];
		end else begin
			do_o[7:0] <= lane0[a_i];
		end
	end

	// the high lane, same write-first rule.
	always_ff @(posedge sys_clk) begin
		if (we_i[1]) begin
			lane1[a_i] <= di_i[15:8];
			do_o[15:8] <= di_i[15:8];
		end else begin
			do_o[15:8] <= lane1[a_i];
		end
	end

	// a write on port one in the same cycle is not seen here.
	always_ff @(posedge sys_clk) begin
		do2_o <= {lane1[a2_i], lane0[a2_i]};
	end

endmodule : fmlbrg_datamem

`default_nettype wire

//--- design/fmlbrg_pkg.sv
// ============================================================
// Constants shared by the cache bridge, the FML target and
// the testbench. Lines are 16 bytes, eight 16-bit words, and
// every FML burst moves exactly one line.
// ============================================================
`default_nettype none

package fmlbrg_pkg;

	// words per cache line, which is also the FML burst length.
	localparam int LINE_WORDS = 8;

	// width of the word offset inside one line.
	localparam int OFFSET_BITS = 3;

	// wishbone cycle type codes.
	// classic cycle, one beat per cyc/stb request.
	localparam logic [2:0] CTI_CLASSIC = 3'b000;

	// incrementing burst, the master moves up one word per ack.
	localparam logic [2:0] CTI_INC_BURST = 3'b010;

	// last beat of a burst.
	localparam logic [2:0] CTI_END = 3'b111;

endpackage : fmlbrg_pkg

`default_nettype wire

//--- design/fmlbrg_sys.sv
// ============================================================
// Cache bridge in front of an on-chip FML memory.
// Defaults give an 8 KB memory behind a 512-byte cache.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module fmlbrg_sys
	import fmlbrg_pkg::*;
#(
	parameter int fml_depth = 13,
	parameter int cache_depth = 9,
	parameter int ack_latency = 3
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst,

	input  wire [fml_depth-1:1] wb_adr_i,
	input  wire [15:0]          wb_dat_i,
	input  wire [1:0]           wb_sel_i,
	input  wire [2:0]           wb_cti_i,
	input  wire                 wb_cyc_i,
	input  wire                 wb_stb_i,
	input  wire                 wb_we_i,
	input  wire                 wb_tga_i,
	output logic [15:0]         wb_dat_o,
	output logic                wb_ack_o,

	input  wire                 dcb_stb_i,
	input  wire [fml_depth-1:1] dcb_adr_i,
	output logic [15:0]         dcb_dat_o,
	output logic                dcb_hit_o
);

	logic [fml_depth-1:0] fml_adr;
	logic fml_stb, fml_we, fml_ack;
	logic [15:0] fml_brg_do, fml_ram_do;

	fmlbrg #(
		.fml_depth(fml_depth),
		.cache_depth(cache_depth)
	) fmlbrg_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_sel_i(wb_sel_i),
		.wb_cti_i(wb_cti_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_tga_i(wb_tga_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.fml_adr_o(fml_adr),
		.fml_stb_o(fml_stb),
		.fml_we_o(fml_we),
		.fml_do_o(fml_brg_do),
		.fml_ack_i(fml_ack),
		.fml_di_i(fml_ram_do),
		.dcb_stb_i(dcb_stb_i),
		.dcb_adr_i(dcb_adr_i),
		.dcb_dat_o(dcb_dat_o),
		.dcb_hit_o(dcb_hit_o)
	);

	fml_ram #(
		.fml_depth(fml_depth),
		.ack_latency(ack_latency)
	) fml_ram_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.fml_adr_i(fml_adr),
		.fml_stb_i(fml_stb),
		.fml_we_i(fml_we),
		.fml_di_i(fml_brg_do),
		.fml_ack_o(fml_ack),
		.fml_do_o(fml_ram_do)
	);

endmodule : fmlbrg_sys

`default_nettype wire

//--- design/fmlbrg_tagmem.sv
// ============================================================
// Tag RAM, one read-write port and one read-only port.
// Both reads are registered, and port one returns the old
// entry on a write. Contents start at zero, so all invalid.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module fmlbrg_tagmem
	import fmlbrg_pkg::*;
#(
	parameter int depth = 5,
	parameter int width = 6
) (
	input  wire             sys_clk,

	input  wire [depth-1:0] a_i,
	input  wire             we_i,
	input  wire [width-1:0] di_i,
	output logic [width-1:0] do_o,

	input  wire [depth-1:0] a2_i,
	output logic [width-1:0] do2_o
);

	logic [width-1:0] tags [0:(1<<depth)-1];

	// every line starts out invalid and clean.
	initial begin
		for (int i = 0; i < (1 << depth); i++) begin
			tags[i] = '0;
		end
	end

	// read-first port used by the bridge state machine.
	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			tags[a_i] <= di_i;
		end
		do_o <= tags[a_i];
	end

	// the direct cache bus only looks.
	always_ff @(posedge sys_clk) begin
		do2_o <= tags[a2_i];
	end

endmodule : fmlbrg_tagmem

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cache bridge testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module tb_fmlbrg_sys -o tb_fmlbrg_sys

./obj_dir/tb_fmlbrg_sys | tee sim.log

if grep -Fxq "Finished with errors" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"

//--- src.f
design/fmlbrg_pkg.sv
design/fmlbrg_tagmem.sv
design/fmlbrg_datamem.sv
design/fmlbrg.sv
design/fml_ram.sv
design/fmlbrg_sys.sv
testbench/tb_fmlbrg_sys.sv

//--- testbench/tb_fmlbrg_sys.sv
// ============================================================
// Testbench for the cache bridge and its FML memory. A shadow
// copy of the memory gives every expected read and DCB word.
// Index 31 is kept out of all Wishbone traffic, so DCB probes
// there must miss. Parameters must match fmlbrg_sys defaults.
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module tb_fmlbrg_sys
	import fmlbrg_pkg::*;
();

	localparam int FML_DEPTH = 13;
	localparam int CACHE_DEPTH = 9;
	localparam int ACK_LATENCY = 3;
	localparam int WA = FML_DEPTH - 1;
	localparam int IW = CACHE_DEPTH - OFFSET_BITS - 1;
	localparam int TW = FML_DEPTH - CACHE_DEPTH;
	localparam int RESERVED_INDEX = (1 << IW) - 1;
	localparam int CLK_PERIOD = 4;
	localparam real DRIVE_DELAY = 0.5;
	localparam logic [31:0] RAND_SEED = 32'h2cfd6475;
	// roughly the number of Wishbone beats and DCB probes in all tests.
	localparam int TOTAL_OPS = 440;
	// a dirty miss costs about this many cycles with the default latency.
	localparam int WORST_CYCLES = 32;
	localparam int TIMEOUT_NS = (TOTAL_OPS * WORST_CYCLES + 500) * CLK_PERIOD;

	logic sys_clk;
	logic sys_rst;
	logic [WA-1:0] wb_adr;
	logic [15:0] wb_dat_w;
	logic [1:0] wb_sel;
	logic [2:0] wb_cti;
	logic wb_cyc, wb_stb, wb_we, wb_tga;
	logic [15:0] wb_dat_r;
	logic wb_ack;
	logic dcb_stb;
	logic [WA-1:0] dcb_adr;
	logic [15:0] dcb_dat;
	logic dcb_hit;

	// the shadow memory mirrors the zero-filled FML target.
	logic [15:0] shadow [0:(1<<WA)-1];
	string test_name;
	logic dcb_miss_expected;
	logic dcb_seen, dcb_miss_q;
	logic [WA-1:0] dcb_adr_q;

	int cmp_errors = 0;
	int cmp_checks = 0;
	int seq_errors = 0;
	int seq_checks = 0;
	int ack_count = 0;
	int dcb_hit_count = 0;

	fmlbrg_sys #(
		.fml_depth(FML_DEPTH),
		.cache_depth(CACHE_DEPTH),
		.ack_latency(ACK_LATENCY)
	) fmlbrg_sys_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_sel_i(wb_sel),
		.wb_cti_i(wb_cti),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_tga_i(wb_tga),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.dcb_stb_i(dcb_stb),
		.dcb_adr_i(dcb_adr),
		.dcb_dat_o(dcb_dat),
		.dcb_hit_o(dcb_hit)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// word address is | tag | index | offset |.
	function automatic logic [WA-1:0] make_addr(input int tg, input int ix, input int off);
		make_addr = {tg[TW-1:0], ix[IW-1:0], off[OFFSET_BITS-1:0]};
	endfunction

	// the cache is transparent, so every read returns the last value written.
	function automatic logic [15:0] ref_read(input logic [WA-1:0] adr);
		ref_read = shadow[adr];
	endfunction

	// a write only changes the lanes whose select is set.
	function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] dat,
			input logic [1:0] sel);
		merge_lanes = old;
		if (sel[0]) begin
			merge_lanes[7:0] = dat[7:0];
		end
		if (sel[1]) begin
			merge_lanes[15:8] = dat[15:8];
		end
	endfunction

	task automatic next_drive();
		@(posedge sys_clk);
		#(DRIVE_DELAY);
	endtask

	// one classic cycle, held until the bridge acks it.
	task automatic single_access(input logic [WA-1:0] adr, input logic we, input logic [15:0] dat,
			input logic [1:0] sel, input logic tga);
		logic got_ack;
		got_ack = 1'b0;
		next_drive();
		wb_adr = adr;
		wb_dat_w = dat;
		wb_sel = sel;
		wb_we = we;
		wb_tga = tga;
		wb_cti = CTI_CLASSIC;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		while (!got_ack) begin
			@(negedge sys_clk);
			got_ack = wb_ack;
			next_drive();
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_tga = 1'b0;
	endtask

	task automatic invalidate_line(input logic [WA-1:0] adr);
		single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b1);
	endtask

	// incrementing burst, the address moves up one word after each ack.
	task automatic run_burst(input logic [WA-1:0] start, input logic we, input int beats);
		logic [WA-1:0] beat_adr;
		logic got_ack;
		int done;
		int acks_before;
		beat_adr = start;
		done = 0;
		next_drive();
		acks_before = ack_count;
		wb_adr = beat_adr;
		wb_dat_w = 16'($urandom);
		wb_sel = 2'b11;
		wb_we = we;
		wb_tga = 1'b0;
		wb_cti = (beats == 1) ? CTI_END : CTI_INC_BURST;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		while (done < beats) begin
			@(negedge sys_clk);
			got_ack = wb_ack;
			next_drive();
			if (got_ack) begin
				done++;
				beat_adr = beat_adr + 1'b1;
				wb_adr = beat_adr;
				wb_dat_w = 16'($urandom);
				wb_cti = (done == beats - 1) ? CTI_END : CTI_INC_BURST;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_cti = CTI_CLASSIC;
		// a stray ack after the last beat would show up here.
		repeat (2) @(posedge sys_clk);
		seq_checks++;
		if (ack_count - acks_before != beats) begin
			seq_errors++;
			$display("[ERROR] %s: burst at %h, expected %0d acks, actual %0d",
				test_name, start, beats, ack_count - acks_before);
		end
	endtask

	// one DCB request, the answer is checked by the compare process.
	task automatic probe_dcb(input logic [WA-1:0] adr, input logic expect_miss);
		next_drive();
		dcb_stb = 1'b1;
		dcb_adr = adr;
		dcb_miss_expected = expect_miss;
		next_drive();
		dcb_stb = 1'b0;
		dcb_miss_expected = 1'b0;
	endtask

	// the DCB answer belongs to the request seen at the previous edge.
	always @(posedge sys_clk) begin
		dcb_seen <= dcb_stb && !sys_rst;
		dcb_adr_q <= dcb_adr;
		dcb_miss_q <= dcb_miss_expected;
	end

	// all outputs are stable at the falling edge.
	always @(negedge sys_clk) begin : compare
		logic [15:0] expected;
		if (sys_rst) begin
			for (int k = 0; k < (1 << WA); k++) begin
				shadow[k] = '0;
			end
		end else begin
			if (wb_ack) begin
				ack_count++;
				if (wb_tga) begin
					// invalidation leaves the memory contents as they are.
				end else if (wb_we) begin
					shadow[wb_adr] = merge_lanes(shadow[wb_adr], wb_dat_w, wb_sel);
				end else begin
					expected = ref_read(wb_adr);
					cmp_checks++;
					if (wb_dat_r !== expected) begin
						cmp_errors++;
						$display("[ERROR] %s: read of word %h, expected %h, actual %h",
							test_name, wb_adr, expected, wb_dat_r);
					end
				end
			end
			if (dcb_seen) begin
				if (dcb_miss_q) begin
					cmp_checks++;
					if (dcb_hit !== 1'b0) begin
						cmp_errors++;
						$display("[ERROR] %s: DCB hit for unmapped word %h, expected 0, actual %b",
							test_name, dcb_adr_q, dcb_hit);
					end
				end else if (dcb_hit) begin
					dcb_hit_count++;
					expected = ref_read(dcb_adr_q);
					cmp_checks++;
					if (dcb_dat !== expected) begin
						cmp_errors++;
						$display("[ERROR] %s: DCB word %h, expected %h, actual %h",
							test_name, dcb_adr_q, expected, dcb_dat);
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
		$display("errors: %0d, checks: %0d", seq_errors + cmp_errors + 1,
			seq_checks + cmp_checks);
		$display("Finished with errors");
		$finish;
	end

	initial begin : sequence_main
		logic [WA-1:0] adr, adr_b;
		logic [1:0] sel;
		logic we;
		int beats;
		void'($urandom(RAND_SEED));
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = 2'b00;
		wb_cti = CTI_CLASSIC;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_tga = 1'b0;
		dcb_stb = 1'b0;
		dcb_adr = '0;
		dcb_miss_expected = 1'b0;
		test_name = "reset";
		repeat (5) @(posedge sys_clk);
		#(DRIVE_DELAY);
		sys_rst = 1'b0;

		// clean-miss read, then write and read hits, then a write that misses.
		test_name = "single";
		for (int i = 0; i < 8; i++) begin
			adr = make_addr($urandom % 16, i, $urandom % 8);
			adr_b = make_addr($urandom % 16, i + 8, $urandom % 8);
			single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b0);
			single_access(adr, 1'b1, 16'($urandom), 2'b11, 1'b0);
			single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b0);
			single_access(adr_b, 1'b1, 16'($urandom), 2'b11, 1'b0);
			single_access(adr_b, 1'b0, 16'h0000, 2'b11, 1'b0);
		end

		test_name = "byte_sel";
		for (int i = 0; i < 16; i++) begin
			adr = make_addr($urandom % 2, 16 + $urandom % 4, $urandom % 8);
			sel = ($urandom % 2 == 0) ? 2'b01 : 2'b10;
			single_access(adr, 1'b1, 16'($urandom), sel, 1'b0);
			single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b0);
		end

		// two indexes and sixteen tags keep evicting dirty lines.
		test_name = "evict";
		for (int i = 0; i < 60; i++) begin
			adr = make_addr($urandom % 16, 20 + $urandom % 2, $urandom % 8);
			we = 1'($urandom % 2);
			sel = 2'(1 + $urandom % 3);
			single_access(adr, we, 16'($urandom), we ? sel : 2'b11, 1'b0);
		end

		// each write burst is read back by a burst over the same words.
		test_name = "burst";
		for (int i = 0; i < 12; i++) begin
			adr = make_addr($urandom % 16, $urandom % 30, $urandom % 8);
			beats = 1 + $urandom % 8;
			run_burst(adr, 1'b1, beats);
			run_burst(adr, 1'b0, beats);
		end

		// dirty lines must be written back before they are dropped.
		test_name = "invalidate";
		for (int i = 0; i < 6; i++) begin
			adr = make_addr($urandom % 16, 24 + i % 4, $urandom % 8);
			single_access(adr, 1'b1, 16'($urandom), 2'b11, 1'b0);
			invalidate_line(adr);
			single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b0);
			invalidate_line(adr);
			single_access(adr, 1'b0, 16'h0000, 2'b11, 1'b0);
		end

		// a probe right after a miss may fall into the refill and miss.
		test_name = "dcb";
		for (int i = 0; i < 20; i++) begin
			adr = make_addr($urandom % 16, $urandom % 30, $urandom % 8);
			single_access(adr, 1'($urandom % 2), 16'($urandom), 2'b11, 1'b0);
			probe_dcb(adr, 1'b0);
			repeat (8) @(posedge sys_clk);
			probe_dcb(adr, 1'b0);
			probe_dcb(make_addr($urandom % 16, RESERVED_INDEX, $urandom % 8), 1'b1);
		end
		next_drive();
		seq_checks++;
		if (dcb_hit_count == 0) begin
			seq_errors++;
			$display("No DCB probe reported a hit, so no DCB data was compared");
		end

		repeat (4) @(posedge sys_clk);
		$display("errors: %0d, checks: %0d", seq_errors + cmp_errors, seq_checks + cmp_checks);
		if (seq_errors + cmp_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule : tb_fmlbrg_sys

`default_nettype wire
